//--- filelist.f
hw/chip8_isa_pkg.sv
hw/chip8_pipe_pkg.sv
hw/chip8_program_mem.sv
hw/chip8_fetch.sv
hw/chip8_decode.sv
hw/chip8_execute.sv
hw/chip8_core.sv
tb/chip8_core_props.sv
tb/chip8_core_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = chip8_core_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# pass only when the pass line shows up in the simulator output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- tb/chip8_core_tb.sv
//**************************************************
// Chip-8 core testbench
// loads directed programs, starts the core and
// checks the writeback stream and the fault level
//**************************************************

`timescale 1ns/1ps

module chip8_core_tb;
    import chip8_isa_pkg::*;
    import chip8_pipe_pkg::*;

    localparam int NUM_TESTS   = 6;
    // cycles per test, reset and loading included
    localparam int TEST_CYCLES = 600;

    // 8xyN nibbles that the core executes
    localparam logic [3:0] ALU_NIBS [9] = '{4'h0, 4'h1, 4'h2, 4'h3, 4'h4,
                                             4'h5, 4'h6, 4'h7, 4'hE};

    // call, return, Bnnn and 1nnn layout from 0x200, markers at each target
    localparam logic [15:0] FLOW_PROG [14] = '{
        16'h6004, 16'h220C, 16'h61A1, 16'hB210, 16'h62EE, 16'h120A, 16'h63C3,
        16'h00EE, 16'h64BB, 16'h64BB, 16'h65B5, 16'h121A, 16'h66DD, 16'h67F7
    };

    logic  Chip8CLK = 1'b0;
    logic  i_reset;
    logic  i_load_valid;
    load_t i_load;
    logic  i_start;
    logic  o_wb_valid;
    wb_t   o_wb;
    logic  o_fault;

    // program image, expected results and a register model
    logic [15:0] prog [$];
    wb_t         exp_q [$];
    byte_t       model [16];
    // every writeback strobe the core has produced
    wb_t         wb_q [$];
    int          wb_base;

    chip8_core #(
        .MEM_BYTES  (4096),
        .STACK_DEPTH(32)
    ) i_chip8_core (
        .Chip8CLK    (Chip8CLK),
        .i_reset     (i_reset),
        .i_load_valid(i_load_valid),
        .i_load      (i_load),
        .i_start     (i_start),
        .o_wb_valid  (o_wb_valid),
        .o_wb        (o_wb),
        .o_fault     (o_fault)
    );

    always #5 Chip8CLK = ~Chip8CLK;

    // outputs change on the rising edge, so sample on the falling one
    always @(negedge Chip8CLK) begin
        if (o_wb_valid === 1'b1) begin
            wb_q.push_back(o_wb);
        end
    end

    initial begin
        repeat (NUM_TESTS * TEST_CYCLES) @(posedge Chip8CLK);
        $display("Watchdog: the run timed out after %0d cycles", NUM_TESTS * TEST_CYCLES);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_wb(input wb_t got, input wb_t exp, input string what);
        logic  bad;
        string got_s;
        string exp_s;
        bad = (got.reg_we !== exp.reg_we) || (got.flag_we !== exp.flag_we);
        // index and data only count when the matching write is on
        if (exp.reg_we && ((got.reg_idx !== exp.reg_idx) || (got.data !== exp.data))) begin
            bad = 1'b1;
        end
        if (exp.flag_we && (got.flag !== exp.flag)) begin
            bad = 1'b1;
        end
        if (bad) begin
            got_s = $sformatf("we=%b r%0h=%02h fwe=%b f=%02h",
                              got.reg_we, got.reg_idx, got.data, got.flag_we, got.flag);
            exp_s = $sformatf("we=%b r%0h=%02h fwe=%b f=%02h",
                              exp.reg_we, exp.reg_idx, exp.data, exp.flag_we, exp.flag);
            abort_run($sformatf("Error at %0t: %s got %s, want %s",
                                $time, what, got_s, exp_s));
        end
    endtask

    task automatic check_fault(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Error at %0t: %s fault is %b, expected %b",
                                $time, what, got, exp));
        end
    endtask

    // rX value and flag of 8xyN, shifts take rY as source
    function automatic void compute_alu(input logic [3:0] nib, input byte_t a, input byte_t b,
                                        output byte_t res, output logic fwe, output byte_t fl);
        logic [8:0] wide;
        res  = 8'h00;
        fwe  = 1'b1;
        fl   = 8'h00;
        wide = {1'b0, a} + {1'b0, b};
        case (nib)
            4'h0: begin
                res = b;
                fwe = 1'b0;
            end
            4'h1: begin
                res = a | b;
                fwe = 1'b0;
            end
            4'h2: begin
                res = a & b;
                fwe = 1'b0;
            end
            4'h3: begin
                res = a ^ b;
                fwe = 1'b0;
            end
            4'h4: begin
                res = wide[7:0];
                fl  = {7'd0, wide[8]};
            end
            // flag is not-borrow
            4'h5: begin
                res = a - b;
                fl  = {7'd0, (a >= b)};
            end
            4'h7: begin
                res = b - a;
                fl  = {7'd0, (b >= a)};
            end
            4'h6: begin
                res = b >> 1;
                fl  = {7'd0, b[0]};
            end
            4'hE: begin
                res = b << 1;
                fl  = {7'd0, b[7]};
            end
            default: fwe = 1'b0;
        endcase
    endfunction

    task automatic new_program();
        prog.delete();
        exp_q.delete();
        // start clears every register
        for (int i = 0; i < 16; i++) begin
            model[i] = 8'h00;
        end
    endtask

    task automatic expect_wb(input reg_idx_t x, input byte_t data, input logic fwe,
                             input byte_t fl);
        wb_t w;
        w         = '0;
        w.reg_we  = 1'b1;
        w.reg_idx = x;
        w.data    = data;
        w.flag_we = fwe;
        w.flag    = fl;
        exp_q.push_back(w);
    endtask

    task automatic set_imm(input reg_idx_t x, input byte_t nn);
        prog.push_back({4'h6, x, nn});
        model[x] = nn;
        expect_wb(x, nn, 1'b0, 8'h00);
    endtask

    // 7xnn wraps with no flag write
    task automatic add_imm(input reg_idx_t x, input byte_t nn);
        prog.push_back({4'h7, x, nn});
        model[x] = model[x] + nn;
        expect_wb(x, model[x], 1'b0, 8'h00);
    endtask

    task automatic alu_instr(input reg_idx_t x, input reg_idx_t y, input logic [3:0] nib);
        byte_t res;
        logic  fwe;
        byte_t fl;
        compute_alu(nib, model[x], model[y], res, fwe, fl);
        prog.push_back({4'h8, x, y, nib});
        model[x] = res;
        // flag written after rX, so it wins for x == F
        if (fwe) begin
            model[FLAG_REG] = fl;
        end
        expect_wb(x, res, fwe, fl);
    endtask

    // every program parks in a jump to itself
    task automatic end_program();
        prog.push_back({4'h1, PROGRAM_START + 12'(2 * prog.size())});
    endtask

    task automatic reset_dut();
        @(negedge Chip8CLK);
        i_reset = 1'b1;
        repeat (10) @(negedge Chip8CLK);
        i_reset = 1'b0;
    endtask

    // one byte per strobe, high byte at the lower address
    task automatic load_program();
        addr_t a;
        a = PROGRAM_START;
        for (int i = 0; i < prog.size(); i++) begin
            @(negedge Chip8CLK);
            i_load_valid = 1'b1;
            i_load.addr  = a;
            i_load.data  = prog[i][15:8];
            @(negedge Chip8CLK);
            i_load.addr  = a + 12'd1;
            i_load.data  = prog[i][7:0];
            a = a + 12'd2;
        end
        @(negedge Chip8CLK);
        i_load_valid = 1'b0;
    endtask

    task automatic start_core();
        @(negedge Chip8CLK);
        i_start = 1'b1;
        wb_base = wb_q.size();
        @(negedge Chip8CLK);
        i_start = 1'b0;
    endtask

    task automatic collect_and_check(input string name);
        int n;
        n = exp_q.size();
        while (wb_q.size() < wb_base + n) begin
            @(posedge Chip8CLK);
        end
        // the closing self-jump must stay silent
        repeat (20) @(posedge Chip8CLK);
        if (wb_q.size() != wb_base + n) begin
            abort_run($sformatf("%s: %0d writebacks arrived but %0d were expected",
                                name, wb_q.size() - wb_base, n));
        end
        for (int k = 0; k < n; k++) begin
            check_wb(wb_q[wb_base + k], exp_q[k], $sformatf("%s writeback %0d", name, k));
        end
    endtask

    task automatic run_program(input string name);
        reset_dut();
        load_program();
        start_core();
        collect_and_check(name);
    endtask

    task automatic idle_before_start();
        int base;
        reset_dut();
        base = wb_q.size();
        repeat (30) @(posedge Chip8CLK);
        if (wb_q.size() != base) begin
            abort_run("idle: a writeback strobe appeared before any start");
        end
        @(negedge Chip8CLK);
        check_fault(o_fault, 1'b0, "idle");
    endtask

    task automatic set_and_add();
        reg_idx_t x;
        new_program();
        for (int i = 0; i < 6; i++) begin
            x = 4'($urandom_range(0, 14));
            set_imm(x, 8'($urandom));
            add_imm(x, 8'($urandom));
            add_imm(x, 8'hFF);
        end
        end_program();
        run_program("set_add");
    endtask

    task automatic alu_with_flag();
        new_program();
        for (int i = 0; i < 9; i++) begin
            set_imm(4'h1, 8'($urandom));
            set_imm(4'h2, 8'($urandom));
            alu_instr(4'h1, 4'h2, ALU_NIBS[i]);
        end
        // forced carry into rF, then read rF back through r0
        set_imm(4'hF, 8'hC0 | 8'($urandom));
        set_imm(4'h2, 8'h80 | 8'($urandom));
        alu_instr(4'hF, 4'h2, 4'h4);
        alu_instr(4'h0, 4'hF, 4'h0);
        end_program();
        run_program("alu");
    endtask

    task automatic skip_conditions();
        byte_t a;
        byte_t b;
        byte_t mk;
        logic  taken;
        new_program();
        for (int kind = 0; kind < 4; kind++) begin
            for (int t = 0; t < 2; t++) begin
                a  = 8'($urandom);
                b  = (t == 1) ? a : (a ^ 8'h01);
                mk = 8'(8'h10 + 2 * kind + t);
                set_imm(4'h1, a);
                set_imm(4'h2, b);
                case (kind)
                    0: prog.push_back({4'h3, 4'h1, b});
                    1: prog.push_back({4'h4, 4'h1, b});
                    2: prog.push_back({4'h5, 4'h1, 4'h2, 4'h0});
                    default: prog.push_back({4'h9, 4'h1, 4'h2, 4'h0});
                endcase
                // 3 and 5 skip on equal, 4 and 9 on not equal
                taken = ((kind == 0) || (kind == 2)) ? (a == b) : (a != b);
                prog.push_back({4'h6, 4'h5, mk});
                if (!taken) begin
                    model[5] = mk;
                    expect_wb(4'h5, mk, 1'b0, 8'h00);
                end
            end
        end
        end_program();
        run_program("skips");
    endtask

    task automatic branch_targets();
        new_program();
        for (int i = 0; i < 14; i++) begin
            prog.push_back(FLOW_PROG[i]);
        end
        end_program();
        // execution order: set r0, subroutine, after return, Bnnn target, 1nnn target
        expect_wb(4'h0, 8'h04, 1'b0, 8'h00);
        expect_wb(4'h3, 8'hC3, 1'b0, 8'h00);
        expect_wb(4'h1, 8'hA1, 1'b0, 8'h00);
        expect_wb(4'h5, 8'hB5, 1'b0, 8'h00);
        expect_wb(4'h7, 8'hF7, 1'b0, 8'h00);
        run_program("branches");
    endtask

    task automatic fault_and_restart();
        new_program();
        set_imm(4'h3, 8'h55);
        // Annn is not executed by this core
        prog.push_back(16'hA123);
        prog.push_back(16'h6466);
        end_program();
        run_program("fault");
        @(negedge Chip8CLK);
        check_fault(o_fault, 1'b1, "after illegal opcode");
        // restart without reset, r3 must read back as zero
        new_program();
        add_imm(4'h3, 8'h01);
        end_program();
        load_program();
        start_core();
        check_fault(o_fault, 1'b0, "after restart");
        collect_and_check("restart");
        check_fault(o_fault, 1'b0, "restarted program");
    endtask

    initial begin
        i_reset      = 1'b1;
        i_load_valid = 1'b0;
        i_load       = '0;
        i_start      = 1'b0;
        wb_base      = 0;
        void'($urandom(32'h39eaa9e5));
        idle_before_start();
        set_and_add();
        alu_with_flag();
        skip_conditions();
        branch_targets();
        fault_and_restart();
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- tb/chip8_core_props.sv
//**************************************************
// Chip-8 core assertions
// bound into the core to watch its strobes
//**************************************************

`timescale 1ns/1ps

module chip8_core_props (
    input logic Chip8CLK,
    input logic i_reset,
    input logic o_wb_valid,
    input logic o_fault,
    input logic i_redirect_valid,
    input logic i_uop_valid
);

    // a faulted core reports no results
    a_no_wb_in_fault: assert property (@(posedge Chip8CLK) disable iff (i_reset)
        !(o_wb_valid && o_fault))
        else $error("writeback strobe while the core is faulted");

    // the fault comes from a uop that sat in execute one cycle earlier
    a_fault_from_uop: assert property (@(posedge Chip8CLK) disable iff (i_reset)
        $rose(o_fault) |-> $past(i_uop_valid))
        else $error("fault rose with no instruction in execute");

    a_strobes_known: assert property (@(posedge Chip8CLK) disable iff (i_reset)
        !$isunknown({i_redirect_valid, o_wb_valid}))
        else $error("redirect or writeback strobe is unknown");

endmodule

bind chip8_core chip8_core_props i_core_props (
    .Chip8CLK        (Chip8CLK),
    .i_reset         (i_reset),
    .o_wb_valid      (o_wb_valid),
    .o_fault         (o_fault),
    .i_redirect_valid(redirect_valid),
    .i_uop_valid     (uop_valid)
);

//--- hw/chip8_core.sv
//**************************************************
// Chip-8 core
// program memory plus fetch, decode and execute
//**************************************************

`timescale 1ns/1ps

module chip8_core #(
    parameter int MEM_BYTES   = 4096,
    parameter int STACK_DEPTH = 32
) (
    input  logic                  Chip8CLK,
    input  logic                  i_reset,
    input  logic                  i_load_valid,
    input  chip8_pipe_pkg::load_t i_load,
    input  logic                  i_start,
    output logic                  o_wb_valid,
    output chip8_pipe_pkg::wb_t   o_wb,
    output logic                  o_fault
);
    import chip8_isa_pkg::*;
    import chip8_pipe_pkg::*;

    addr_t   rd_addr;
    opcode_u rd_word;
    logic    fetch_valid;
    fetch_t  fetch;
    logic    uop_valid;
    uop_t    uop;
    // redirect doubles as the decode flush
    logic    redirect_valid;
    addr_t   redirect_addr;
    logic    stop;

    chip8_program_mem #(
        .MEM_BYTES(MEM_BYTES)
    ) i_program_mem (
        .Chip8CLK    (Chip8CLK),
        .i_load_valid(i_load_valid),
        .i_load      (i_load),
        .i_rd_addr   (rd_addr),
        .o_rd_word   (rd_word)
    );

    chip8_fetch i_fetch (
        .Chip8CLK        (Chip8CLK),
        .i_reset         (i_reset),
        .i_start         (i_start),
        .i_stop          (stop),
        .i_redirect_valid(redirect_valid),
        .i_redirect_addr (redirect_addr),
        .i_rd_word       (rd_word),
        .o_rd_addr       (rd_addr),
        .o_fetch_valid   (fetch_valid),
        .o_fetch         (fetch)
    );

    chip8_decode i_decode (
        .Chip8CLK     (Chip8CLK),
        .i_reset      (i_reset),
        .i_flush      (redirect_valid),
        .i_fetch_valid(fetch_valid),
        .i_fetch      (fetch),
        .o_uop_valid  (uop_valid),
        .o_uop        (uop)
    );

    chip8_execute #(
        .STACK_DEPTH(STACK_DEPTH)
    ) i_execute (
        .Chip8CLK        (Chip8CLK),
        .i_reset         (i_reset),
        .i_start         (i_start),
        .i_uop_valid     (uop_valid),
        .i_uop           (uop),
        .o_redirect_valid(redirect_valid),
        .o_redirect_addr (redirect_addr),
        .o_stop          (stop),
        .o_wb_valid      (o_wb_valid),
        .o_wb            (o_wb),
        .o_fault         (o_fault)
    );

endmodule

//--- hw/chip8_execute.sv
//**************************************************
// Chip-8 execute stage
// register file, ALU with flag, branch resolution,
// call stack, writeback and fault
//**************************************************

`timescale 1ns/1ps

module chip8_execute #(
    parameter int STACK_DEPTH = 32
) (
    input  logic                 Chip8CLK,
    input  logic                 i_reset,
    input  logic                 i_start,
    input  logic                 i_uop_valid,
    input  chip8_pipe_pkg::uop_t i_uop,
    output logic                 o_redirect_valid,
    output chip8_isa_pkg::addr_t o_redirect_addr,
    output logic                 o_stop,
    output logic                 o_wb_valid,
    output chip8_pipe_pkg::wb_t  o_wb,
    output logic                 o_fault
);
    import chip8_isa_pkg::*;
    import chip8_pipe_pkg::*;

    localparam int SPW = $clog2(STACK_DEPTH);

    byte_t        regs [16];
    addr_t        stack [STACK_DEPTH];
    logic [SPW:0] sp;
    logic [SPW:0] sp_m1;
    logic         fault;
    byte_t        rx;
    byte_t        ry;
    logic [8:0]   sum_xy;
    logic [8:0]   diff_xy;
    logic [8:0]   diff_yx;
    logic         live;
    logic         commit;
    logic         taken;
    logic         fault_d;
    logic         do_push;
    logic         do_pop;
    addr_t        tgt;
    wb_t          wb_d;

    assign rx      = regs[i_uop.x];
    assign ry      = regs[i_uop.y];
    assign sp_m1   = sp - 1'b1;
    // bit 8 is the carry out, or the borrow for the subtracts
    assign sum_xy  = {1'b0, rx} + {1'b0, ry};
    assign diff_xy = {1'b0, rx} - {1'b0, ry};
    assign diff_yx = {1'b0, ry} - {1'b0, rx};

    // uop in flight is stale on a start and ignored once faulted
    assign live   = i_uop_valid & ~fault & ~i_start;
    assign commit = live & ~fault_d;

    always_comb begin
        wb_d         = '0;
        wb_d.reg_idx = i_uop.x;
        taken        = 1'b0;
        // skip target by default
        tgt          = i_uop.pc + 12'd4;
        fault_d      = 1'b0;
        do_push      = 1'b0;
        do_pop       = 1'b0;
        if (i_uop.illegal) begin
            fault_d = 1'b1;
        end else begin
            case (i_uop.leader)
                // only 00EE gets past decode
                LD_SYS: begin
                    if (sp == '0) begin
                        fault_d = 1'b1;
                    end else begin
                        do_pop = 1'b1;
                        taken  = 1'b1;
                        tgt    = stack[sp_m1[SPW-1:0]];
                    end
                end
                LD_JUMP: begin
                    taken = 1'b1;
                    tgt   = i_uop.target;
                end
                LD_CALL: begin
                    if (sp == (SPW+1)'(STACK_DEPTH)) begin
                        fault_d = 1'b1;
                    end else begin
                        do_push = 1'b1;
                        taken   = 1'b1;
                        tgt     = i_uop.target;
                    end
                end
                LD_SKIP_EQ_IMM: taken = (rx == i_uop.imm);
                LD_SKIP_NE_IMM: taken = (rx != i_uop.imm);
                LD_SKIP_EQ_REG: taken = (rx == ry);
                LD_SKIP_NE_REG: taken = (rx != ry);
                LD_SET_IMM: begin
                    wb_d.reg_we = 1'b1;
                    wb_d.data   = i_uop.imm;
                end
                // no carry out for 7xnn
                LD_ADD_IMM: begin
                    wb_d.reg_we = 1'b1;
                    wb_d.data   = rx + i_uop.imm;
                end
                LD_ALU: begin
                    wb_d.reg_we = 1'b1;
                    case (i_uop.alu_op)
                        ALU_MOV: wb_d.data = ry;
                        ALU_OR:  wb_d.data = rx | ry;
                        ALU_AND: wb_d.data = rx & ry;
                        ALU_XOR: wb_d.data = rx ^ ry;
                        ALU_ADD: begin
                            wb_d.data    = sum_xy[7:0];
                            wb_d.flag_we = 1'b1;
                            wb_d.flag    = {7'd0, sum_xy[8]};
                        end
                        ALU_SUB: begin
                            wb_d.data    = diff_xy[7:0];
                            wb_d.flag_we = 1'b1;
                            wb_d.flag    = {7'd0, ~diff_xy[8]};
                        end
                        ALU_SUBN: begin
                            wb_d.data    = diff_yx[7:0];
                            wb_d.flag_we = 1'b1;
                            wb_d.flag    = {7'd0, ~diff_yx[8]};
                        end
                        // shifts take rY as the source and leave rY alone
                        ALU_SHR: begin
                            wb_d.data    = ry >> 1;
                            wb_d.flag_we = 1'b1;
                            wb_d.flag    = {7'd0, ry[0]};
                        end
                        ALU_SHL: begin
                            wb_d.data    = ry << 1;
                            wb_d.flag_we = 1'b1;
                            wb_d.flag    = {7'd0, ry[7]};
                        end
                        default: wb_d.reg_we = 1'b0;
                    endcase
                end
                // Bnnn wraps within the 12-bit space
                LD_JUMP_R0: begin
                    taken = 1'b1;
                    tgt   = i_uop.target + {4'h0, regs[0]};
                end
                default: fault_d = 1'b1;
            endcase
        end
    end

    // a start also flushes decode, fetch restarts at the program start itself
    assign o_redirect_valid = i_start | (commit & taken);
    assign o_redirect_addr  = tgt;

    always_ff @(posedge Chip8CLK) begin
        if (i_reset || i_start) begin
            fault      <= 1'b0;
            sp         <= '0;
            o_wb_valid <= 1'b0;
        end else begin
            o_wb_valid <= commit & (wb_d.reg_we | wb_d.flag_we);
            if (live && fault_d) begin
                fault <= 1'b1;
            end
            if (commit && do_push) begin
                sp <= sp + 1'b1;
            end else if (commit && do_pop) begin
                sp <= sp_m1;
            end
        end
    end

    always_ff @(posedge Chip8CLK) begin
        if (i_start) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (commit) begin
            if (wb_d.reg_we) begin
                regs[wb_d.reg_idx] <= wb_d.data;
            end
            // flag written last, so it wins when x is rF
            if (wb_d.flag_we) begin
                regs[FLAG_REG] <= wb_d.flag;
            end
        end
    end

    // return address is the instruction after the call
    always_ff @(posedge Chip8CLK) begin
        if (commit && do_push) begin
            stack[sp[SPW-1:0]] <= i_uop.pc + 12'd2;
        end
    end

    always_ff @(posedge Chip8CLK) begin
        o_wb <= wb_d;
    end

    assign o_fault = fault;
    assign o_stop  = fault;

endmodule

//--- hw/chip8_decode.sv
//**************************************************
// Chip-8 decode stage
// splits opcode fields, names the operation and
// flags opcodes that this core does not execute
//**************************************************

`timescale 1ns/1ps

module chip8_decode (
    input  logic                   Chip8CLK,
    input  logic                   i_reset,
    input  logic                   i_flush,
    input  logic                   i_fetch_valid,
    input  chip8_pipe_pkg::fetch_t i_fetch,
    output logic                   o_uop_valid,
    output chip8_pipe_pkg::uop_t   o_uop
);
    import chip8_isa_pkg::*;
    import chip8_pipe_pkg::*;

    opcode_u op;
    uop_t    uop_d;

    assign op = i_fetch.op;

    always_comb begin
        // Lxyn view for registers and constant, Lnnn view for the address
        uop_d.leader  = op.xyn.leader;
        uop_d.alu_op  = ALU_MOV;
        uop_d.x       = op.xyn.x;
        uop_d.y       = op.xyn.y;
        uop_d.imm     = {op.xyn.y, op.xyn.n};
        uop_d.target  = op.nnn.addr;
        uop_d.pc      = i_fetch.pc;
        uop_d.illegal = 1'b0;
        case (op.xyn.leader)
            // only the return survives from the 0nnn group
            LD_SYS: uop_d.illegal = (op != RET_OPCODE);
            LD_ALU: begin
                case (op.xyn.n)
                    4'h0, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7, 4'hE:
                        uop_d.alu_op = alu_op_e'(op.xyn.n);
                    default: uop_d.illegal = 1'b1;
                endcase
            end
            LD_JUMP, LD_CALL, LD_SKIP_EQ_IMM, LD_SKIP_NE_IMM, LD_SKIP_EQ_REG,
            LD_SET_IMM, LD_ADD_IMM, LD_SKIP_NE_REG, LD_JUMP_R0: uop_d.illegal = 1'b0;
            // index, random, draw, key and misc groups
            default: uop_d.illegal = 1'b1;
        endcase
    end

    // a flush drops whatever fetch presents this cycle
    always_ff @(posedge Chip8CLK) begin
        if (i_reset) begin
            o_uop_valid <= 1'b0;
        end else begin
            o_uop_valid <= i_fetch_valid & ~i_flush;
        end
    end

    always_ff @(posedge Chip8CLK) begin
        o_uop <= uop_d;
    end

endmodule

//--- hw/chip8_fetch.sv
//**************************************************
// Chip-8 fetch stage
// program counter, sequential reads and redirects
//**************************************************

`timescale 1ns/1ps

module chip8_fetch (
    input  logic                   Chip8CLK,
    input  logic                   i_reset,
    input  logic                   i_start,
    input  logic                   i_stop,
    input  logic                   i_redirect_valid,
    input  chip8_isa_pkg::addr_t   i_redirect_addr,
    input  chip8_isa_pkg::opcode_u i_rd_word,
    output chip8_isa_pkg::addr_t   o_rd_addr,
    output logic                   o_fetch_valid,
    output chip8_pipe_pkg::fetch_t o_fetch
);
    import chip8_isa_pkg::*;

    logic  running;
    logic  issue;
    addr_t pc;
    logic  rd_valid;
    addr_t rd_pc;

    // the read address is the pc itself
    assign o_rd_addr = pc;
    assign issue     = running & ~i_stop;

    always_ff @(posedge Chip8CLK) begin
        if (i_reset) begin
            running  <= 1'b0;
            rd_valid <= 1'b0;
            pc       <= PROGRAM_START;
        end else if (i_start) begin
            // start wins over a pending stop or redirect
            running  <= 1'b1;
            rd_valid <= 1'b0;
            pc       <= PROGRAM_START;
        end else begin
            if (i_stop) begin
                running <= 1'b0;
            end
            // a read issued alongside a redirect is already stale
            rd_valid <= issue & ~i_redirect_valid;
            if (i_redirect_valid) begin
                pc <= i_redirect_addr;
            end else if (issue) begin
                pc <= pc + 12'd2;
            end
        end
    end

    // address of the read in flight, paired with the returned word
    always_ff @(posedge Chip8CLK) begin
        rd_pc <= pc;
    end

    assign o_fetch_valid = rd_valid;
    assign o_fetch.pc    = rd_pc;
    assign o_fetch.op    = i_rd_word;

endmodule

//--- hw/chip8_program_mem.sv
//**************************************************
// Chip-8 program memory
// byte storage loaded by the host, read as a
// big-endian opcode pair one cycle after the address
//**************************************************

`timescale 1ns/1ps

module chip8_program_mem #(
    parameter int MEM_BYTES = 4096
) (
    input  logic                   Chip8CLK,
    input  logic                   i_load_valid,
    input  chip8_pipe_pkg::load_t  i_load,
    input  chip8_isa_pkg::addr_t   i_rd_addr,
    output chip8_isa_pkg::opcode_u o_rd_word
);
    import chip8_isa_pkg::*;

    localparam int AW = $clog2(MEM_BYTES);

    byte_t         mem [MEM_BYTES];
    logic [AW-1:0] wr_idx;
    logic [AW-1:0] hi_idx;
    logic [AW-1:0] lo_idx;

    // addresses wrap modulo the memory size
    assign wr_idx = i_load.addr[AW-1:0];
    assign hi_idx = i_rd_addr[AW-1:0];
    assign lo_idx = hi_idx + AW'(1);

    always_ff @(posedge Chip8CLK) begin
        if (i_load_valid) begin
            mem[wr_idx] <= i_load.data;
        end
    end

    // high byte sits at the lower address
    always_ff @(posedge Chip8CLK) begin
        o_rd_word <= {mem[hi_idx], mem[lo_idx]};
    end

endmodule

//--- hw/chip8_pipe_pkg.sv
//**************************************************
// Chip-8 pipeline payloads
// structs passed between stages and to the ports
//**************************************************

package chip8_pipe_pkg;

    // host write of one program byte
    typedef struct packed {
        chip8_isa_pkg::addr_t addr;
        chip8_isa_pkg::byte_t data;
    } load_t;

    // fetched opcode with the address it came from
    typedef struct packed {
        chip8_isa_pkg::addr_t   pc;
        chip8_isa_pkg::opcode_u op;
    } fetch_t;

    // decoded instruction held between decode and execute
    typedef struct packed {
        chip8_isa_pkg::leader_e  leader;
        chip8_isa_pkg::alu_op_e  alu_op;
        chip8_isa_pkg::reg_idx_t x;
        chip8_isa_pkg::reg_idx_t y;
        chip8_isa_pkg::byte_t    imm;
        chip8_isa_pkg::addr_t    target;
        chip8_isa_pkg::addr_t    pc;
        logic                    illegal;
    } uop_t;

    // architectural result of one executed instruction
    typedef struct packed {
        logic                    reg_we;
        chip8_isa_pkg::reg_idx_t reg_idx;
        chip8_isa_pkg::byte_t    data;
        logic                    flag_we;
        chip8_isa_pkg::byte_t    flag;
    } wb_t;

endpackage

//--- hw/chip8_isa_pkg.sv
//**************************************************
// Chip-8 instruction set definitions
// opcode word views, leader and ALU codes, and the
// architectural constants shared by all stages
//**************************************************

package chip8_isa_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [11:0] addr_t;
    typedef logic [3:0]  reg_idx_t;

    // programs always begin here
    localparam addr_t PROGRAM_START = 12'h200;
    // carry, not-borrow and shift-out land in rF
    localparam reg_idx_t FLAG_REG = 4'hF;
    localparam logic [15:0] RET_OPCODE = 16'h00EE;

    // leading nibble of the opcode
    typedef enum logic [3:0] {
        LD_SYS         = 4'h0,
        LD_JUMP        = 4'h1,
        LD_CALL        = 4'h2,
        LD_SKIP_EQ_IMM = 4'h3,
        LD_SKIP_NE_IMM = 4'h4,
        LD_SKIP_EQ_REG = 4'h5,
        LD_SET_IMM     = 4'h6,
        LD_ADD_IMM     = 4'h7,
        LD_ALU         = 4'h8,
        LD_SKIP_NE_REG = 4'h9,
        LD_INDEX       = 4'hA,
        LD_JUMP_R0     = 4'hB,
        LD_RAND        = 4'hC,
        LD_DRAW        = 4'hD,
        LD_KEY         = 4'hE,
        LD_MISC        = 4'hF
    } leader_e;

    // low nibble of 8xyN
    typedef enum logic [3:0] {
        ALU_MOV  = 4'h0,
        ALU_OR   = 4'h1,
        ALU_AND  = 4'h2,
        ALU_XOR  = 4'h3,
        ALU_ADD  = 4'h4,
        ALU_SUB  = 4'h5,
        ALU_SHR  = 4'h6,
        ALU_SUBN = 4'h7,
        ALU_SHL  = 4'hE
    } alu_op_e;

    // one opcode word seen either as Lxyn or as Lnnn
    // the nn constant is the low byte of the Lxyn view
    typedef union packed {
        struct packed {
            leader_e    leader;
            reg_idx_t   x;
            reg_idx_t   y;
            logic [3:0] n;
        } xyn;
        struct packed {
            leader_e leader;
            addr_t   addr;
        } nnn;
    } opcode_u;

endpackage
